// ==== filelist.f ====
rtl/thread_ctl_pkg.sv
rtl/thread_scheduler.sv
rtl/creg_access_stage.sv
rtl/control_registers.sv
rtl/writeback_stage.sv
rtl/thread_ctl_top.sv
sim/tb_clock_gen.sv
sim/thread_ctl_tb.sv

// ==== rtl/control_registers.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register file
// Holds the thread and interrupt enables and the last
// fault of every thread, applies register writes and
// answers register reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module control_registers
#(
	parameter thread_ctl_pkg::core_id_t CORE_ID = 4'h0
)
(
	input logic clk,
	input logic reset,
	input logic creg_read_en,
	input logic creg_write_en,
	input thread_ctl_pkg::control_register_t creg_index,
	input thread_ctl_pkg::scalar_t creg_write_val,
	input thread_ctl_pkg::thread_idx_t creg_thread,
	input logic wb_fault,
	input thread_ctl_pkg::fault_record_t wb_fault_record,
	output logic read_valid_int,
	output thread_ctl_pkg::scalar_t read_val_int,
	output thread_ctl_pkg::thread_mask_t thread_enable,
	output thread_ctl_pkg::thread_mask_t interrupt_enable
);

	// Last fault of every thread
	thread_ctl_pkg::scalar_t fault_pc[thread_ctl_pkg::THREADS_PER_CORE];
	thread_ctl_pkg::fault_reason_t fault_reason[thread_ctl_pkg::THREADS_PER_CORE];

	// Enables and fault reasons, which have a defined state after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Only thread 0 runs after reset
			thread_enable <= thread_ctl_pkg::thread_mask_t'(1);
			interrupt_enable <= '0;
			for (int i = 0; i < thread_ctl_pkg::THREADS_PER_CORE; i++)
				fault_reason[i] <= thread_ctl_pkg::FR_RESET;
		end
		else
		begin
			// A faulting thread has its interrupts turned off
			if (wb_fault)
			begin
				fault_reason[wb_fault_record.thread] <= wb_fault_record.reason;
				interrupt_enable[wb_fault_record.thread] <= 1'b0;
			end

			// A write in the same cycle comes last and so takes priority
			if (creg_write_en)
			begin
				case (creg_index)
					thread_ctl_pkg::CR_THREAD_ENABLE:
						thread_enable <= creg_write_val[thread_ctl_pkg::THREADS_PER_CORE - 1:0];
					thread_ctl_pkg::CR_HALT_THREAD:
						thread_enable[creg_thread] <= 1'b0;
					thread_ctl_pkg::CR_INTERRUPT_ENABLE:
						interrupt_enable[creg_thread] <= 1'b1;
					thread_ctl_pkg::CR_HALT:
						thread_enable <= '0;
					default:
						;
				endcase
			end
		end
	end

	// Fault pc storage only has meaning once the reason is no longer FR_RESET
	always_ff @(posedge clk)
	begin
		if (wb_fault)
			fault_pc[wb_fault_record.thread] <= wb_fault_record.pc;
	end

	// Read strobe, one cycle after the decode
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			read_valid_int <= 1'b0;
		else
			read_valid_int <= creg_read_en;
	end

	// Read data, looked up for the thread that made the request
	always_ff @(posedge clk)
	begin
		if (creg_read_en)
		begin
			case (creg_index)
				// Core id sits above the thread number
				thread_ctl_pkg::CR_THREAD_ID:
					read_val_int <= thread_ctl_pkg::scalar_t'({CORE_ID, creg_thread});
				thread_ctl_pkg::CR_FAULT_PC:
					read_val_int <= fault_pc[creg_thread];
				thread_ctl_pkg::CR_FAULT_REASON:
					read_val_int <= thread_ctl_pkg::scalar_t'(fault_reason[creg_thread]);
				default:
					read_val_int <= '0;
			endcase
		end
	end

	// The access stage must never hand over a read and a write at once
	no_read_with_write: assert property (@(posedge clk) disable iff (reset)
		!(creg_read_en && creg_write_en))
		else $error("Control register read and write in the same cycle");

endmodule

// ==== rtl/creg_access_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register access stage
// Captures the accepted request with its thread and
// decodes it into read, write and trap strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module creg_access_stage
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input thread_ctl_pkg::creg_request_t req,
	input logic issue_valid,
	input thread_ctl_pkg::thread_idx_t issue_thread,
	output logic creg_read_en,
	output logic creg_write_en,
	output thread_ctl_pkg::control_register_t creg_index,
	output thread_ctl_pkg::scalar_t creg_write_val,
	output thread_ctl_pkg::thread_idx_t creg_thread,
	output logic trap_valid,
	output thread_ctl_pkg::fault_record_t trap_record
);

	// The one request this stage holds
	thread_ctl_pkg::issued_request_t issued;
	logic issued_valid;

	logic request_accepted;
	logic op_read;
	logic op_write;
	logic op_trap;
	logic legal_read;
	logic legal_write;

	// Requests offered without an issue slot are dropped here
	assign request_accepted = req_valid && issue_valid;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			issued_valid <= 1'b0;
		else
			issued_valid <= request_accepted;
	end

	always_ff @(posedge clk)
	begin
		if (request_accepted)
		begin
			issued.req <= req;
			issued.thread <= issue_thread;
		end
	end

	// Opcode decode, qualified by the stage holding a request
	assign op_read = issued_valid && issued.req.op == thread_ctl_pkg::OP_CREG_READ;
	assign op_write = issued_valid && issued.req.op == thread_ctl_pkg::OP_CREG_WRITE;
	assign op_trap = issued_valid && issued.req.op == thread_ctl_pkg::OP_TRAP;

	// Readable and writable register sets do not overlap
	assign legal_read = issued.req.index inside {thread_ctl_pkg::CR_THREAD_ID,
		thread_ctl_pkg::CR_FAULT_PC, thread_ctl_pkg::CR_FAULT_REASON};
	assign legal_write = issued.req.index inside {thread_ctl_pkg::CR_THREAD_ENABLE,
		thread_ctl_pkg::CR_HALT_THREAD, thread_ctl_pkg::CR_INTERRUPT_ENABLE,
		thread_ctl_pkg::CR_HALT};

	assign creg_read_en = op_read && legal_read;
	assign creg_write_en = op_write && legal_write;
	assign creg_index = issued.req.index;
	assign creg_write_val = issued.req.value;
	assign creg_thread = issued.thread;

	// An access to a missing register turns into a fault instead of a strobe
	assign trap_valid = op_trap || (op_read && !legal_read) || (op_write && !legal_write);

	always_comb
	begin
		// Traps keep the reason they were raised with
		if (op_trap)
			trap_record.reason = issued.req.trap_reason;
		else
			trap_record.reason = thread_ctl_pkg::FR_ILLEGAL_CREG;
		trap_record.pc = issued.req.pc;
		trap_record.thread = issued.thread;
	end

endmodule

// ==== rtl/thread_ctl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thread control shared definitions
// Constants, register and fault encodings, and the
// packed records that move between the scheduler,
// the control register path and the writeback stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package thread_ctl_pkg;

	// Number of hardware threads in one core
	localparam int THREADS_PER_CORE = 4;

	// A thread number, wide enough for every thread of the core
	typedef logic [$clog2(THREADS_PER_CORE) - 1:0] thread_idx_t;

	// One bit per thread, bit n belongs to thread n
	typedef logic [THREADS_PER_CORE - 1:0] thread_mask_t;

	// Identifier of the core, reported through CR_THREAD_ID
	typedef logic [3:0] core_id_t;

	// Data words and program counters share one width
	typedef logic [31:0] scalar_t;

	// Control register indexes
	// Indexes not listed here are unimplemented and raise a fault when accessed
	typedef enum logic [4:0]
	{
		CR_THREAD_ID = 5'd0,
		CR_FAULT_PC = 5'd2,
		CR_FAULT_REASON = 5'd3,
		CR_INTERRUPT_ENABLE = 5'd4,
		CR_HALT_THREAD = 5'd29,
		CR_THREAD_ENABLE = 5'd30,
		CR_HALT = 5'd31
	} control_register_t;

	// Reason stored with each fault
	// FR_RESET is what every thread reports until its first fault
	typedef enum logic [3:0]
	{
		FR_RESET = 4'd0,
		FR_ILLEGAL_CREG = 4'd1,
		FR_TRAP = 4'd2
	} fault_reason_t;

	// Operation carried by a control register request
	typedef enum logic [1:0]
	{
		OP_NOP = 2'd0,
		OP_CREG_READ = 2'd1,
		OP_CREG_WRITE = 2'd2,
		OP_TRAP = 2'd3
	} opcode_t;

	// Request as offered by the logic outside the slice
	// The value field is only meaningful for writes, trap_reason only for traps
	typedef struct packed
	{
		opcode_t op;
		control_register_t index;
		scalar_t value;
		scalar_t pc;
		fault_reason_t trap_reason;
	} creg_request_t;

	// Request paired with the thread the scheduler gave it to
	typedef struct packed
	{
		creg_request_t req;
		thread_idx_t thread;
	} issued_request_t;

	// One fault, as reported outside and as stored per thread
	typedef struct packed
	{
		fault_reason_t reason;
		scalar_t pc;
		thread_idx_t thread;
	} fault_record_t;

	// Result of a control register read, tagged with its thread
	typedef struct packed
	{
		scalar_t value;
		thread_idx_t thread;
	} read_result_t;

endpackage

// ==== rtl/thread_ctl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thread control top level
// Scheduler, register access stage, register file
// and writeback stage of one core, with the core id
// handed down to the register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module thread_ctl_top
#(
	parameter thread_ctl_pkg::core_id_t CORE_ID = 4'h5
)
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input thread_ctl_pkg::creg_request_t req,
	output logic issue_valid,
	output thread_ctl_pkg::thread_idx_t issue_thread,
	output logic read_valid,
	output thread_ctl_pkg::read_result_t read_result,
	output logic fault_valid,
	output thread_ctl_pkg::fault_record_t fault,
	output thread_ctl_pkg::thread_mask_t thread_enable,
	output thread_ctl_pkg::thread_mask_t interrupt_enable
);

	// Decode strobes from the access stage
	logic creg_read_en;
	logic creg_write_en;
	thread_ctl_pkg::control_register_t creg_index;
	thread_ctl_pkg::scalar_t creg_write_val;
	thread_ctl_pkg::thread_idx_t creg_thread;
	logic trap_valid;
	thread_ctl_pkg::fault_record_t trap_record;

	// Register file read path into writeback
	logic read_valid_int;
	thread_ctl_pkg::scalar_t read_val_int;

	// Faults returned from writeback for storage
	logic wb_fault;
	thread_ctl_pkg::fault_record_t wb_fault_record;

	// The scheduler follows the enables held in the register file
	thread_scheduler thread_scheduler_inst (
		.clk(clk),
		.reset(reset),
		.thread_enable(thread_enable),
		.req_valid(req_valid),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread)
	);

	creg_access_stage creg_access_stage_inst (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.creg_read_en(creg_read_en),
		.creg_write_en(creg_write_en),
		.creg_index(creg_index),
		.creg_write_val(creg_write_val),
		.creg_thread(creg_thread),
		.trap_valid(trap_valid),
		.trap_record(trap_record)
	);

	control_registers #(
		.CORE_ID(CORE_ID)
	) control_registers_inst (
		.clk(clk),
		.reset(reset),
		.creg_read_en(creg_read_en),
		.creg_write_en(creg_write_en),
		.creg_index(creg_index),
		.creg_write_val(creg_write_val),
		.creg_thread(creg_thread),
		.wb_fault(wb_fault),
		.wb_fault_record(wb_fault_record),
		.read_valid_int(read_valid_int),
		.read_val_int(read_val_int),
		.thread_enable(thread_enable),
		.interrupt_enable(interrupt_enable)
	);

	writeback_stage writeback_stage_inst (
		.clk(clk),
		.reset(reset),
		.read_valid_int(read_valid_int),
		.read_val_int(read_val_int),
		.creg_thread(creg_thread),
		.trap_valid(trap_valid),
		.trap_record(trap_record),
		.read_valid(read_valid),
		.read_result(read_result),
		.fault_valid(fault_valid),
		.fault(fault),
		.wb_fault(wb_fault),
		.wb_fault_record(wb_fault_record)
	);

endmodule

// ==== rtl/thread_scheduler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin thread scheduler
// Points at one enabled thread at a time and moves on
// to the next enabled thread after each accepted
// request, or when its thread gets disabled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module thread_scheduler
(
	input logic clk,
	input logic reset,
	input thread_ctl_pkg::thread_mask_t thread_enable,
	input logic req_valid,
	output logic issue_valid,
	output thread_ctl_pkg::thread_idx_t issue_thread
);

	// Thread that owns the current issue slot
	thread_ctl_pkg::thread_idx_t current_thread;

	// Next enabled thread after current_thread, in rising order with wraparound
	thread_ctl_pkg::thread_idx_t next_thread;
	thread_ctl_pkg::thread_idx_t candidate;
	logic found;

	logic request_accepted;
	logic advance;

	// The slot is only offered while its thread is still enabled
	assign issue_valid = thread_enable[current_thread];
	assign issue_thread = current_thread;

	assign request_accepted = req_valid && issue_valid;

	// Move on after a request, or right away when the thread has been disabled
	assign advance = request_accepted || !issue_valid;

	// Search the threads after the current one; the last candidate is the
	// current thread itself, so a lone enabled thread keeps the slot
	always_comb
	begin
		next_thread = current_thread;
		candidate = current_thread;
		found = 1'b0;
		for (int i = 1; i <= thread_ctl_pkg::THREADS_PER_CORE; i++)
		begin
			candidate = thread_ctl_pkg::thread_idx_t'(current_thread + i);
			if (!found && thread_enable[candidate])
			begin
				next_thread = candidate;
				found = 1'b1;
			end
		end
	end

	// With no thread enabled next_thread equals current_thread and the pointer rests
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			current_thread <= '0;
		else if (advance)
			current_thread <= next_thread;
	end

	// An empty slot with some thread enabled is filled again one cycle later,
	// unless the enables themselves changed at that edge
	empty_slot_refilled: assert property (@(posedge clk) disable iff (reset)
		(!issue_valid && thread_enable != '0)
		|=> (issue_valid || thread_enable != $past(thread_enable)))
		else $error("Scheduler left the slot empty with thread %0d", issue_thread);

	// With more than one thread enabled an accepted request always hands the slot on
	rotation_moves_on: assert property (@(posedge clk) disable iff (reset)
		(request_accepted && $countones(thread_enable) > 1)
		|=> issue_thread != $past(issue_thread))
		else $error("Scheduler kept thread %0d after a request", issue_thread);

endmodule

// ==== rtl/writeback_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback stage
// Presents register read results and fault records
// at the outputs, and returns each fault to the
// control register file for storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module writeback_stage
(
	input logic clk,
	input logic reset,
	input logic read_valid_int,
	input thread_ctl_pkg::scalar_t read_val_int,
	input thread_ctl_pkg::thread_idx_t creg_thread,
	input logic trap_valid,
	input thread_ctl_pkg::fault_record_t trap_record,
	output logic read_valid,
	output thread_ctl_pkg::read_result_t read_result,
	output logic fault_valid,
	output thread_ctl_pkg::fault_record_t fault,
	output logic wb_fault,
	output thread_ctl_pkg::fault_record_t wb_fault_record
);

	// Thread of the read now being looked up in the register file
	// The read data lags the decode by one cycle, so the thread is held to match
	thread_ctl_pkg::thread_idx_t read_thread;

	always_ff @(posedge clk)
	begin
		read_thread <= creg_thread;
	end

	// Strobes carry reset, payloads follow them
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_valid <= 1'b0;
			fault_valid <= 1'b0;
		end
		else
		begin
			read_valid <= read_valid_int;
			fault_valid <= trap_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (read_valid_int)
		begin
			read_result.value <= read_val_int;
			read_result.thread <= read_thread;
		end

		// Traps and illegal accesses arrive here already formed as fault records
		if (trap_valid)
			fault <= trap_record;
	end

	// The register file stores exactly the fault that the outputs show
	assign wb_fault = fault_valid;
	assign wb_fault_record = fault;

	// A read result and a fault come from different requests in different stages
	// and must never carry the same request, so a fault never has a result behind it
	fault_has_no_result: assert property (@(posedge clk) disable iff (reset)
		trap_valid |=> !read_valid_int)
		else $error("Faulting request also produced a read");

endmodule

// ==== sim/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// 40 ns clock with reset held for the first 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen
(
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 8;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// Reset drops on a falling edge so the first live rising edge sees a quiet design
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== sim/thread_ctl_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thread control testbench
// Applies a table of control register requests to
// the core slice and compares scheduler slots,
// enables, read results and faults every cycle
// against a reference model of the slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module thread_ctl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam thread_ctl_pkg::core_id_t CORE_ID = 4'h5;
	localparam int MAX_EDGES = 64;
	localparam int DRAIN_CYCLES = 4;

	// One table row is one cycle of stimulus
	typedef struct packed
	{
		logic valid;
		thread_ctl_pkg::creg_request_t req;
	} table_entry_t;

	logic clk;
	logic reset;
	logic req_valid;
	thread_ctl_pkg::creg_request_t req;
	logic issue_valid;
	thread_ctl_pkg::thread_idx_t issue_thread;
	logic read_valid;
	thread_ctl_pkg::read_result_t read_result;
	logic fault_valid;
	thread_ctl_pkg::fault_record_t fault;
	thread_ctl_pkg::thread_mask_t thread_enable;
	thread_ctl_pkg::thread_mask_t interrupt_enable;

	table_entry_t stimulus[$];
	logic [31:0] lfsr_state = 32'h38d1;
	int cycle_count = 0;
	int timeout_limit = MAX_EDGES;

	// Reference model of the architectural state, as it stands after each edge
	thread_ctl_pkg::thread_mask_t m_enable = 4'b0001;
	thread_ctl_pkg::thread_mask_t m_irq_enable = 4'b0000;
	thread_ctl_pkg::thread_idx_t m_pointer = '0;
	thread_ctl_pkg::fault_reason_t m_reason[thread_ctl_pkg::THREADS_PER_CORE] =
		'{default: thread_ctl_pkg::FR_RESET};
	thread_ctl_pkg::scalar_t m_pc[thread_ctl_pkg::THREADS_PER_CORE] = '{default: '0};

	// Events scheduled by edge number
	// Writes land one edge after acceptance and stored faults two edges after
	logic write_due[MAX_EDGES] = '{default: 1'b0};
	thread_ctl_pkg::issued_request_t write_item[MAX_EDGES];
	logic store_due[MAX_EDGES] = '{default: 1'b0};
	thread_ctl_pkg::fault_record_t store_item[MAX_EDGES];
	// Outputs expected in the cycle that follows a given edge
	logic read_due[MAX_EDGES] = '{default: 1'b0};
	thread_ctl_pkg::read_result_t read_item[MAX_EDGES];
	logic fault_due[MAX_EDGES] = '{default: 1'b0};
	thread_ctl_pkg::fault_record_t fault_item[MAX_EDGES];

	tb_clock_gen clock_gen_inst (
		.clk(clk),
		.reset(reset)
	);

	thread_ctl_top #(
		.CORE_ID(CORE_ID)
	) thread_ctl_top_inst (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.read_valid(read_valid),
		.read_result(read_result),
		.fault_valid(fault_valid),
		.fault(fault),
		.thread_enable(thread_enable),
		.interrupt_enable(interrupt_enable)
	);

	task automatic fail_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_thread(input string name, input thread_ctl_pkg::thread_idx_t exp,
		input thread_ctl_pkg::thread_idx_t act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_mask(input string name, input thread_ctl_pkg::thread_mask_t exp,
		input thread_ctl_pkg::thread_mask_t act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_read(input thread_ctl_pkg::read_result_t exp,
		input thread_ctl_pkg::read_result_t act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: read_result expected value %h thread %0d, got %h %0d",
				$time, exp.value, exp.thread, act.value, act.thread);
			fail_run();
		end
	endtask

	task automatic check_fault(input thread_ctl_pkg::fault_record_t exp,
		input thread_ctl_pkg::fault_record_t act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: fault (reason pc thread) expected %0d %h %0d, got %0d %h %0d",
				$time, exp.reason, exp.pc, exp.thread, act.reason, act.pc, act.thread);
			fail_run();
		end
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Each bit of the word costs one LFSR step
	task automatic take_random_word(output thread_ctl_pkg::scalar_t word);
		for (int i = 0; i < 32; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			word = {word[30:0], lfsr_state[0]};
		end
	endtask

	task automatic add_entry(input thread_ctl_pkg::opcode_t op,
		input thread_ctl_pkg::control_register_t index, input thread_ctl_pkg::scalar_t value,
		input thread_ctl_pkg::scalar_t pc);
		table_entry_t entry;

		entry.valid = 1'b1;
		entry.req.op = op;
		entry.req.index = index;
		entry.req.value = value;
		entry.req.pc = pc;
		if (op == thread_ctl_pkg::OP_TRAP)
			entry.req.trap_reason = thread_ctl_pkg::FR_TRAP;
		else
			entry.req.trap_reason = thread_ctl_pkg::FR_RESET;
		stimulus.push_back(entry);
	endtask

	task automatic add_idle(input int count);
		repeat (count)
			stimulus.push_back('0);
	endtask

	// Next enabled thread in rising order, the current one if it is the only candidate
	function automatic thread_ctl_pkg::thread_idx_t next_enabled(
		input thread_ctl_pkg::thread_idx_t cur, input thread_ctl_pkg::thread_mask_t en);
		thread_ctl_pkg::thread_idx_t cand;

		for (int i = 1; i <= thread_ctl_pkg::THREADS_PER_CORE; i++)
		begin
			cand = thread_ctl_pkg::thread_idx_t'(cur + i);
			if (en[cand])
				return cand;
		end
		return cur;
	endfunction

	// Core id in bits 5 to 2 and thread in bits 1 to 0, fault reason zero-extended
	function automatic thread_ctl_pkg::scalar_t read_value(
		input thread_ctl_pkg::control_register_t index, input thread_ctl_pkg::thread_idx_t t);
		case (index)
			thread_ctl_pkg::CR_THREAD_ID:
				return (thread_ctl_pkg::scalar_t'(CORE_ID) << 2) | thread_ctl_pkg::scalar_t'(t);
			thread_ctl_pkg::CR_FAULT_PC:
				return m_pc[t];
			default:
				return thread_ctl_pkg::scalar_t'(m_reason[t]);
		endcase
	endfunction

	task automatic apply_write(input thread_ctl_pkg::issued_request_t w);
		case (w.req.index)
			thread_ctl_pkg::CR_THREAD_ENABLE:
				m_enable = w.req.value[thread_ctl_pkg::THREADS_PER_CORE - 1:0];
			thread_ctl_pkg::CR_HALT_THREAD:
				m_enable[w.thread] = 1'b0;
			thread_ctl_pkg::CR_INTERRUPT_ENABLE:
				m_irq_enable[w.thread] = 1'b1;
			default:
				m_enable = '0;
		endcase
	endtask

	// Advances the model across edge e with the request that was offered before it
	task automatic model_edge(input int e, input table_entry_t offered);
		logic slot_open;
		logic accepted;
		logic raise;
		thread_ctl_pkg::thread_idx_t t;
		thread_ctl_pkg::fault_record_t rec;

		slot_open = m_enable[m_pointer];
		accepted = offered.valid && slot_open;
		t = m_pointer;
		// The scheduler moves on using the enables from before this edge
		if (accepted || !slot_open)
			m_pointer = next_enabled(m_pointer, m_enable);
		if (store_due[e])
		begin
			m_reason[store_item[e].thread] = store_item[e].reason;
			m_pc[store_item[e].thread] = store_item[e].pc;
			m_irq_enable[store_item[e].thread] = 1'b0;
		end
		if (write_due[e])
			apply_write(write_item[e]);
		if (accepted)
		begin
			raise = 1'b0;
			rec.reason = thread_ctl_pkg::FR_ILLEGAL_CREG;
			rec.pc = offered.req.pc;
			rec.thread = t;
			case (offered.req.op)
				thread_ctl_pkg::OP_CREG_READ:
					if (offered.req.index inside {thread_ctl_pkg::CR_THREAD_ID,
						thread_ctl_pkg::CR_FAULT_PC, thread_ctl_pkg::CR_FAULT_REASON})
					begin
						read_due[e + 2] = 1'b1;
						read_item[e + 2].value = read_value(offered.req.index, t);
						read_item[e + 2].thread = t;
					end
					else
						raise = 1'b1;
				thread_ctl_pkg::OP_CREG_WRITE:
					if (offered.req.index inside {thread_ctl_pkg::CR_INTERRUPT_ENABLE,
						thread_ctl_pkg::CR_HALT_THREAD, thread_ctl_pkg::CR_THREAD_ENABLE,
						thread_ctl_pkg::CR_HALT})
					begin
						write_due[e + 1] = 1'b1;
						write_item[e + 1].req = offered.req;
						write_item[e + 1].thread = t;
					end
					else
						raise = 1'b1;
				thread_ctl_pkg::OP_TRAP:
				begin
					raise = 1'b1;
					rec.reason = offered.req.trap_reason;
				end
				default:
					;
			endcase
			if (raise)
			begin
				fault_due[e + 1] = 1'b1;
				fault_item[e + 1] = rec;
				store_due[e + 2] = 1'b1;
				store_item[e + 2] = rec;
			end
		end
	endtask

	// Compares every output in the cycle that follows edge e
	task automatic check_cycle(input int e);
		check_flag("issue_valid", m_enable[m_pointer], issue_valid);
		if (m_enable[m_pointer])
			check_thread("issue_thread", m_pointer, issue_thread);
		check_mask("thread_enable", m_enable, thread_enable);
		check_mask("interrupt_enable", m_irq_enable, interrupt_enable);
		if (read_valid !== read_due[e])
		begin
			if (read_valid === 1'b1)
				$display("A read result appeared at %0t ns with no read expected", $time);
			else
				$display("An expected read result did not appear at %0t ns", $time);
			fail_run();
		end
		else if (read_due[e])
			check_read(read_item[e], read_result);
		if (fault_valid !== fault_due[e])
		begin
			if (fault_valid === 1'b1)
				$display("A fault appeared at %0t ns with no fault expected", $time);
			else
				$display("An expected fault did not appear at %0t ns", $time);
			fail_run();
		end
		else if (fault_due[e])
			check_fault(fault_item[e], fault);
	endtask

	// The run may take the table plus a short drain, and never much more
	always @(posedge clk)
	begin
		if (!reset)
		begin
			cycle_count++;
			if (cycle_count > timeout_limit)
			begin
				$display("Timeout after %0d cycles without finishing the table", cycle_count);
				fail_run();
			end
		end
	end

	initial
	begin
		table_entry_t offered;
		table_entry_t previous;
		thread_ctl_pkg::scalar_t trap_pc;

		// Message times are shown in whole nanoseconds
		$timeformat(-9, 0, "", 0);
		req_valid = 1'b0;
		req = '0;
		previous = '0;

		// Reset state seen from thread 0, then threads 0, 1 and 3 are enabled
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_THREAD_ID, '0, 32'h1000);
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_FAULT_REASON, '0, 32'h1004);
		add_entry(thread_ctl_pkg::OP_CREG_WRITE, thread_ctl_pkg::CR_THREAD_ENABLE, 32'hb, 32'h1008);
		repeat (4)
			add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_THREAD_ID, '0, 32'h100c);
		// Every running thread turns its interrupts on, then thread 0 traps
		repeat (3)
			add_entry(thread_ctl_pkg::OP_CREG_WRITE, thread_ctl_pkg::CR_INTERRUPT_ENABLE, '0,
				32'h1010);
		take_random_word(trap_pc);
		add_entry(thread_ctl_pkg::OP_TRAP, thread_ctl_pkg::CR_THREAD_ID, '0, trap_pc);
		add_idle(2);
		// Threads 1 and 3 still hold FR_RESET while thread 0 holds FR_TRAP
		repeat (3)
			add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_FAULT_REASON, '0,
				32'h1014);
		// Accesses to registers that do not exist, or in the wrong direction
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::control_register_t'(5'd7), '0,
			32'h100);
		add_entry(thread_ctl_pkg::OP_CREG_WRITE, thread_ctl_pkg::control_register_t'(5'd5),
			32'hffff, 32'h204);
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_FAULT_PC, '0, 32'h1018);
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_INTERRUPT_ENABLE, '0, 32'h308);
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_FAULT_PC, '0, 32'h101c);
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_FAULT_REASON, '0, 32'h1020);
		// Thread 1 halts itself, then the whole core halts
		add_entry(thread_ctl_pkg::OP_CREG_WRITE, thread_ctl_pkg::CR_HALT_THREAD, '0, 32'h1024);
		repeat (3)
			add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_THREAD_ID, '0, 32'h1028);
		add_entry(thread_ctl_pkg::OP_CREG_WRITE, thread_ctl_pkg::CR_HALT, '0, 32'h102c);
		add_idle(1);
		// With no slot offered these two are dropped
		add_entry(thread_ctl_pkg::OP_CREG_READ, thread_ctl_pkg::CR_THREAD_ID, '0, 32'h1030);
		take_random_word(trap_pc);
		add_entry(thread_ctl_pkg::OP_TRAP, thread_ctl_pkg::CR_THREAD_ID, '0, trap_pc);

		timeout_limit = stimulus.size() + 20;
		@(negedge reset);
		for (int k = 0; k < stimulus.size() + DRAIN_CYCLES; k++)
		begin
			@(posedge clk);
			model_edge(k, previous);
			if (k < stimulus.size())
				offered = stimulus[k];
			else
				offered = '0;
			req_valid <= offered.valid;
			req <= offered.req;
			previous = offered;
			@(negedge clk);
			check_cycle(k);
		end
		$display("TEST OK");
		$finish;
	end

endmodule
